// File: serial_fetch.f
verilog/fetch_pkg.sv
verilog/shift_reg.sv
verilog/pc_ctrl.sv
verilog/fetch_ctrl.sv
verilog/instr_decoder.sv
verilog/rd_deser.sv
verilog/serial_fetch.sv
test/serial_fetch_chk.sv
test/tb_serial_fetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide pass or fail from the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_serial_fetch \
   -f serial_fetch.f -o tb_serial_fetch > build.log 2>&1 \
   || { cat build.log; exit 1; }

./obj_dir/tb_serial_fetch > sim.log 2>&1
cat sim.log
grep -qx "Verification passed" sim.log && exit 0 || exit 1

// File: test/tb_serial_fetch.sv
`timescale 1ns/10ps

module tb_serial_fetch import fetch_pkg::*; ();

   localparam addr_t RESET_PC   = 32'h8;
   localparam int    N_INSTR    = 60;
   localparam int    MAX_CYCLES = N_INSTR * (33 + 4) + 100;  // worst ack latency is 4.

   logic      clk        = 1'b0;
   logic      i_rst      = 1'b1;
   logic      i_ibus_ack = 1'b0;
   instr_t    i_ibus_rdt = '0;
   addr_t     o_ibus_adr;
   logic      o_ibus_cyc;
   logic      o_rd_wen;
   reg_addr_t o_rd_addr;
   addr_t     o_rd_data;

   instr_t      mem [64];
   int unsigned wait_cnt;
   logic        pending    = 1'b0;
   addr_t       exp_pc     = RESET_PC;
   addr_t       nxt_pc;
   logic        exp_wen    = 1'b0;
   reg_addr_t   exp_wa;
   addr_t       exp_wd;
   logic        cyc_prev   = 1'b0;
   int          req_count  = 0;
   logic        all_done   = 1'b0;
   logic        timed_out  = 1'b0;
   int          cycles     = 0;
   int          value_errs = 0;
   int          proto_errs = 0;

   always #4 clk = ~clk;

   serial_fetch #(
      .RESET_PC (RESET_PC)
   ) i_serial_fetch (
      .clk        (clk),
      .i_rst      (i_rst),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_rd_wen   (o_rd_wen),
      .o_rd_addr  (o_rd_addr),
      .o_rd_data  (o_rd_data)
   );

   function automatic instr_t jal_word(input reg_addr_t rd, input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
   endfunction

   function automatic instr_t u_word(input logic [6:0] opc, input reg_addr_t rd,
                                     input logic [19:0] imm);
      return {imm, rd, opc};
   endfunction

   // next pc and the rd write that one instruction should produce.
   function automatic void ref_step(input addr_t pc, input instr_t ins, output addr_t nxt,
                                    output logic wen, output reg_addr_t wa, output addr_t wd);
      addr_t j_imm;
      addr_t u_imm;
      j_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      u_imm = {ins[31:12], 12'd0};
      nxt   = pc + 32'd4;
      wa    = ins[11:7];
      wd    = '0;
      wen   = 1'b0;
      if (ins[6:0] == OPC_JAL) begin
         nxt = pc + j_imm;
         wd  = pc + 32'd4;
         wen = (wa != 5'd0);
      end else if (ins[6:0] == OPC_LUI) begin
         wd  = u_imm;
         wen = (wa != 5'd0);
      end else if (ins[6:0] == OPC_AUIPC) begin
         wd  = pc + u_imm;
         wen = (wa != 5'd0);
      end
   endfunction

   task automatic check_addr(input addr_t exp, input addr_t act);
      if (act !== exp) begin
         $display("Error: o_ibus_adr expected %h, got %h", exp, act);
         value_errs++;
      end
   endtask

   task automatic check_rd_addr(input reg_addr_t exp, input reg_addr_t act);
      if (act !== exp) begin
         $display("Error: o_rd_addr expected %h, got %h", exp, act);
         value_errs++;
      end
   endtask

   task automatic check_rd_data(input addr_t exp, input addr_t act);
      if (act !== exp) begin
         $display("Error: o_rd_data expected %h, got %h", exp, act);
         value_errs++;
      end
   endtask

   // slave answers one to four cycles after the request appears.
   always @(negedge clk) begin
      if (i_rst) begin
         i_ibus_ack = 1'b0;
         pending    = 1'b0;
      end else if (i_ibus_ack) begin
         i_ibus_ack = 1'b0;
      end else if (o_ibus_cyc && !pending) begin
         pending  = 1'b1;
         wait_cnt = $urandom % 4;
      end else if (pending) begin
         if (wait_cnt == 0) begin
            i_ibus_rdt = mem[o_ibus_adr[7:2]];
            i_ibus_ack = 1'b1;
            pending    = 1'b0;
         end else begin
            wait_cnt--;
         end
      end
   end

   always @(negedge clk) begin
      if (i_rst) begin
         cyc_prev = 1'b0;
      end else if (!all_done) begin
         if (o_rd_wen) begin
            if (!exp_wen) begin
               $display("unexpected write pulse to register x%0d", o_rd_addr);
               proto_errs++;
            end else begin
               check_rd_addr(exp_wa, o_rd_addr);
               check_rd_data(exp_wd, o_rd_data);
               exp_wen = 1'b0;
            end
         end
         if (o_ibus_cyc && !cyc_prev) begin
            if (exp_wen) begin
               $display("write to register x%0d missing before request at %h", exp_wa, exp_pc);
               proto_errs++;
               exp_wen = 1'b0;
            end
            check_addr(exp_pc, o_ibus_adr);
            if (req_count == N_INSTR) begin
               all_done = 1'b1;
            end else begin
               ref_step(exp_pc, mem[exp_pc[7:2]], nxt_pc, exp_wen, exp_wa, exp_wd);
               exp_pc = nxt_pc;
               req_count++;
            end
         end
         cyc_prev = o_ibus_cyc;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         timed_out <= 1'b1;
      end
   end

   initial begin
      void'($urandom(2014));
      for (int i = 0; i < 64; i++) begin
         mem[i] = 32'h13 | (32'(i) << 20);  // addi x0, x0, index.
      end
      mem[2]  = u_word(OPC_LUI, 5'd5, 20'h12345);
      mem[3]  = u_word(OPC_AUIPC, 5'd6, 20'habcde);
      mem[4]  = 32'h0000_0013;
      mem[5]  = jal_word(5'd1, 21'h40);
      mem[7]  = u_word(OPC_AUIPC, 5'd31, 20'h80000);
      mem[8]  = 32'hffff_ffff;  // unknown opcode.
      mem[9]  = jal_word(5'd7, 21'h80);
      mem[21] = u_word(OPC_LUI, 5'd0, 20'hfffff);
      mem[22] = u_word(OPC_AUIPC, 5'd0, 20'h00001);
      mem[23] = jal_word(5'd0, 21'h1fffc0);  // back by 64 bytes.
      mem[45] = u_word(OPC_AUIPC, 5'd11, 20'hfffff);
      mem[46] = u_word(OPC_LUI, 5'd10, 20'h00001);
      repeat (4) @(negedge clk);
      i_rst = 1'b0;
      wait (all_done || timed_out);
      if (!all_done) begin
         $display("timeout after %0d cycles, %0d of %0d instructions done",
                  cycles, req_count, N_INSTR);
      end
      $display("value errors %0d, protocol errors %0d", value_errs, proto_errs);
      if (all_done && value_errs == 0 && proto_errs == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: test/serial_fetch_chk.sv
`timescale 1ns/10ps

module serial_fetch_chk import fetch_pkg::*; (
   input logic  clk,
   input logic  i_rst,
   input addr_t i_ibus_adr,
   input logic  i_ibus_cyc,
   input logic  i_ibus_ack,
   input logic  i_rd_wen
);

   adr_hold: assert property (@(posedge clk) disable iff (i_rst)
      (i_ibus_cyc && !i_ibus_ack) |=> $stable(i_ibus_adr))
      else $error("instruction address changed before the ack");

   adr_align: assert property (@(posedge clk) disable iff (i_rst)
      i_ibus_cyc |-> !i_ibus_adr[0])
      else $error("instruction address has bit 0 set");

   // write pulse and the next fetch ack are always cycles apart.
   wen_vs_ack: assert property (@(posedge clk) disable iff (i_rst) !(i_rd_wen && i_ibus_ack))
      else $error("register write in the same cycle as a bus ack");

   wen_single: assert property (@(posedge clk) disable iff (i_rst) i_rd_wen |=> !i_rd_wen)
      else $error("register write pulse longer than one cycle");

endmodule

bind serial_fetch serial_fetch_chk u_fetch_chk (
   .clk        (clk),
   .i_rst      (i_rst),
   .i_ibus_adr (o_ibus_adr),
   .i_ibus_cyc (o_ibus_cyc),
   .i_ibus_ack (i_ibus_ack),
   .i_rd_wen   (o_rd_wen)
);

// File: verilog/serial_fetch.sv
`timescale 1ns/10ps

module serial_fetch import fetch_pkg::*; #(
   parameter addr_t RESET_PC = DEF_RESET_PC
) (
   input  logic      clk,
   input  logic      i_rst,
   output addr_t     o_ibus_adr,
   output logic      o_ibus_cyc,
   input  logic      i_ibus_ack,
   input  instr_t    i_ibus_rdt,
   output logic      o_rd_wen,
   output reg_addr_t o_rd_addr,
   output addr_t     o_rd_data
);

   logic      pc_en;
   bit_cnt_t  cnt;
   logic      run_done;
   logic      imm;
   logic      jump;
   logic      utype;
   logic      pc_rel;
   logic      rd_link;
   logic      rd_en;
   reg_addr_t rd_addr;
   logic      rd_bit;

   fetch_ctrl u_fetch_ctrl (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_ibus_cyc (o_ibus_cyc),
      .i_ibus_ack (i_ibus_ack),
      .o_pc_en    (pc_en),
      .o_cnt      (cnt),
      .o_run_done (run_done)
   );

   pc_ctrl #(
      .RESET_PC (RESET_PC)
   ) u_pc_ctrl (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_pc_en    (pc_en),
      .i_cnt      (cnt),
      .i_jump     (jump),
      .i_utype    (utype),
      .i_pc_rel   (pc_rel),
      .i_rd_link  (rd_link),
      .i_imm      (imm),
      .i_ibus_ack (i_ibus_ack),
      .o_rd       (rd_bit),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc)
   );

   instr_decoder u_instr_decoder (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_pc_en    (pc_en),
      .o_imm      (imm),
      .o_jump     (jump),
      .o_utype    (utype),
      .o_pc_rel   (pc_rel),
      .o_rd_link  (rd_link),
      .o_rd_en    (rd_en),
      .o_rd_addr  (rd_addr)
   );

   rd_deser u_rd_deser (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_pc_en    (pc_en),
      .i_rd       (rd_bit),
      .i_run_done (run_done),
      .i_rd_en    (rd_en),
      .i_rd_addr  (rd_addr),
      .o_rd_wen   (o_rd_wen),
      .o_rd_addr  (o_rd_addr),
      .o_rd_data  (o_rd_data)
   );

endmodule

// File: verilog/rd_deser.sv
`timescale 1ns/10ps

module rd_deser import fetch_pkg::*; (
   input  logic      clk,
   input  logic      i_rst,
   input  logic      i_pc_en,
   input  logic      i_rd,
   input  logic      i_run_done,
   input  logic      i_rd_en,
   input  reg_addr_t i_rd_addr,
   output logic      o_rd_wen,
   output reg_addr_t o_rd_addr,
   output addr_t     o_rd_data
);

   addr_t data_r;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         data_r <= '0;
      end else if (i_pc_en) begin
         data_r <= {i_rd, data_r[31:1]};  // lsb arrives first.
      end
   end

   assign o_rd_wen  = i_run_done & i_rd_en;
   assign o_rd_addr = i_rd_addr;
   assign o_rd_data = data_r;

endmodule

// File: verilog/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder import fetch_pkg::*; (
   input  logic      clk,
   input  logic      i_rst,
   input  logic      i_ibus_ack,
   input  instr_t    i_ibus_rdt,
   input  logic      i_pc_en,
   output logic      o_imm,
   output logic      o_jump,
   output logic      o_utype,
   output logic      o_pc_rel,
   output logic      o_rd_link,
   output logic      o_rd_en,
   output reg_addr_t o_rd_addr
);

   logic      is_jal;
   logic      is_lui;
   logic      is_auipc;
   reg_addr_t rd;
   addr_t     imm;
   addr_t     imm_r;

   assign is_jal   = (i_ibus_rdt[6:0] == OPC_JAL);
   assign is_lui   = (i_ibus_rdt[6:0] == OPC_LUI);
   assign is_auipc = (i_ibus_rdt[6:0] == OPC_AUIPC);
   assign rd       = i_ibus_rdt[11:7];

   always_comb begin
      if (is_jal) begin
         imm = {{12{i_ibus_rdt[31]}}, i_ibus_rdt[19:12], i_ibus_rdt[20],
                i_ibus_rdt[30:21], 1'b0};
      end else begin
         imm = {i_ibus_rdt[31:12], 12'd0};  // u-type, unused for no-ops.
      end
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_r     <= imm;
         o_rd_addr <= rd;
      end else if (i_pc_en) begin
         imm_r <= {1'b0, imm_r[31:1]};  // next bit to the lsb.
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_jump    <= 1'b0;
         o_utype   <= 1'b0;
         o_pc_rel  <= 1'b0;
         o_rd_link <= 1'b0;
         o_rd_en   <= 1'b0;
      end else if (i_ibus_ack) begin
         o_jump    <= is_jal;
         o_utype   <= is_lui | is_auipc;
         o_pc_rel  <= is_jal | is_auipc;
         o_rd_link <= is_jal;
         o_rd_en   <= (is_jal | is_lui | is_auipc) & (rd != 5'd0);
      end
   end

   assign o_imm = imm_r[0];

endmodule

// File: verilog/fetch_ctrl.sv
`timescale 1ns/10ps

module fetch_ctrl import fetch_pkg::*; (
   input  logic     clk,
   input  logic     i_rst,
   input  logic     i_ibus_cyc,
   input  logic     i_ibus_ack,
   output logic     o_pc_en,
   output bit_cnt_t o_cnt,
   output logic     o_run_done
);

   ctrl_state_t state_r;
   bit_cnt_t    cnt_r;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state_r <= ST_FETCH;
         cnt_r   <= '0;
      end else begin
         case (state_r)
            ST_FETCH: begin
               cnt_r <= '0;
               if (i_ibus_cyc & i_ibus_ack) begin
                  state_r <= ST_RUN;  // word latched this cycle.
               end
            end
            ST_RUN: begin
               cnt_r <= cnt_r + 5'd1;
               if (cnt_r == 5'd31) begin
                  state_r <= ST_WRITE;
               end
            end
            ST_WRITE: begin
               state_r <= ST_FETCH;
            end
            default: begin
               state_r <= ST_FETCH;
            end
         endcase
      end
   end

   assign o_pc_en    = (state_r == ST_RUN);
   assign o_cnt      = cnt_r;
   assign o_run_done = (state_r == ST_WRITE);

endmodule

// File: verilog/pc_ctrl.sv
`timescale 1ns/10ps

module pc_ctrl import fetch_pkg::*; #(
   parameter addr_t RESET_PC = DEF_RESET_PC
) (
   input  logic     clk,
   input  logic     i_rst,
   input  logic     i_pc_en,
   input  bit_cnt_t i_cnt,
   input  logic     i_jump,
   input  logic     i_utype,
   input  logic     i_pc_rel,
   input  logic     i_rd_link,
   input  logic     i_imm,
   input  logic     i_ibus_ack,
   output logic     o_rd,
   output addr_t    o_ibus_adr,
   output logic     o_ibus_cyc
);

   logic        pc;
   logic [30:0] pc_par;
   logic        new_pc;
   logic        en_pc_r;
   logic        plus_4;
   logic [1:0]  sum_4;
   logic [1:0]  sum_off;
   logic        cy_4_r;
   logic        cy_off_r;
   logic        offset_a;
   logic        pc_plus_off;

   shift_reg #(
      .LEN  (32),
      .INIT (RESET_PC)
   ) pc_reg (
      .clk   (clk),
      .i_rst (i_rst),
      .i_en  (i_pc_en),
      .i_d   (new_pc),
      .o_q   (pc),
      .o_par (pc_par)
   );

   assign plus_4   = i_pc_en & (i_cnt == 5'd2);  // +4 enters at bit 2.
   assign sum_4    = {1'b0, pc} + {1'b0, plus_4} + {1'b0, cy_4_r};

   assign offset_a = i_pc_rel & pc;
   assign sum_off  = {1'b0, offset_a} + {1'b0, i_imm} + {1'b0, cy_off_r};

   // en_pc_r is still low in the first bit of a run, forcing bit 0 to zero.
   assign pc_plus_off = sum_off[0] & en_pc_r;

   assign new_pc = i_jump ? pc_plus_off : sum_4[0];
   assign o_rd   = (i_utype & pc_plus_off) | (i_rd_link & sum_4[0]);

   assign o_ibus_adr = {pc_par, pc};  // full pc, kept aligned by the mask.
   assign o_ibus_cyc = en_pc_r & ~i_pc_en;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         en_pc_r  <= 1'b1;
         cy_4_r   <= 1'b0;
         cy_off_r <= 1'b0;
      end else begin
         cy_4_r   <= i_pc_en & sum_4[1];
         cy_off_r <= i_pc_en & sum_off[1];
         if (i_pc_en) begin
            en_pc_r <= 1'b1;
         end else if (o_ibus_cyc & i_ibus_ack) begin
            en_pc_r <= 1'b0;  // cycle ends, run starts next.
         end
      end
   end

endmodule

// File: verilog/shift_reg.sv
`timescale 1ns/10ps

module shift_reg #(
   parameter int             LEN  = 32,
   parameter logic [LEN-1:0] INIT = '0
) (
   input  logic           clk,
   input  logic           i_rst,
   input  logic           i_en,
   input  logic           i_d,
   output logic           o_q,
   output logic [LEN-2:0] o_par
);

   logic [LEN-1:0] data_r;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         data_r <= INIT;
      end else if (i_en) begin
         data_r <= {i_d, data_r[LEN-1:1]};  // new bit at the top, lsb leaves.
      end
   end

   assign o_q   = data_r[0];
   assign o_par = data_r[LEN-1:1];

endmodule

// File: verilog/fetch_pkg.sv
package fetch_pkg;

   typedef logic [31:0] addr_t;      // byte address, also the pc.
   typedef logic [31:0] instr_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [4:0]  bit_cnt_t;   // serial bit index.

   typedef enum logic [1:0] {
      ST_FETCH,
      ST_RUN,
      ST_WRITE
   } ctrl_state_t;

   // program start, fetched right after reset.
   localparam addr_t DEF_RESET_PC = 32'd8;

   localparam logic [6:0] OPC_JAL   = 7'b1101111;
   localparam logic [6:0] OPC_LUI   = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC = 7'b0010111;

endpackage
